// ==== src.f ====
+incdir+source
source/fma_pkg.sv
source/fma_decode.sv
source/fma_sign.sv
source/fma_execute.sv
source/fma_result.sv
source/fma_top.sv
tests/fma_checker.sv
tests/fma_assertions.sv
tests/fma_tb.sv

// ==== Bender.yml ====
package:
  name: fma

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/fma_pkg.sv
      - source/fma_decode.sv
      - source/fma_sign.sv
      - source/fma_execute.sv
      - source/fma_result.sv
      - source/fma_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/fma_checker.sv
      - tests/fma_assertions.sv
      - tests/fma_tb.sv

// ==== tests/fma_tb.sv ====
//////////////////////////////////////////////////
// fma testbench
// clock, reset, vector table, stimulus loop, timeout
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "fma_defines.svh"

module fma_tb;
	import fma_pkg::*;

	typedef struct {
		string                  name;
		fma_op_e                op;
		fma_rnd_e               rnd;
		logic [`FMA_WORD_W-1:0] x;
		logic [`FMA_WORD_W-1:0] y;
		logic [`FMA_WORD_W-1:0] z;
		logic [`FMA_WORD_W-1:0] w;     // expected result
		logic                   inv;   // expected invalid
		int                     gap;   // idle cycles after this entry
	} vec_t;

	logic                   clk;
	logic                   rst_n;
	logic                   in_valid;
	fma_op_e                op;
	fma_rnd_e               rnd;
	logic [`FMA_WORD_W-1:0] x;
	logic [`FMA_WORD_W-1:0] y;
	logic [`FMA_WORD_W-1:0] z;
	logic                   out_valid;
	logic [`FMA_WORD_W-1:0] w;
	logic                   invalid;

	vec_t vecs[$];
	int   limit = 0;    // cycle budget, set once the table is built
	int   cycles = 0;

	fma_top fma_top_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.op        (op),
		.rnd       (rnd),
		.x         (x),
		.y         (y),
		.z         (z),
		.out_valid (out_valid),
		.w         (w),
		.invalid   (invalid)
	);

	fma_checker checker_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.out_valid (out_valid),
		.w         (w),
		.invalid   (invalid)
	);

	task automatic add_vec(input string name, input fma_op_e vop, input fma_rnd_e vrnd,
		input logic [15:0] vx, input logic [15:0] vy, input logic [15:0] vz,
		input logic [15:0] vw, input logic vinv, input int gap);
		vecs.push_back('{name, vop, vrnd, vx, vy, vz, vw, vinv, gap});
	endtask

	//////////////////////////////////////////////////
	// vector table, expected values by hand
	//////////////////////////////////////////////////
	task automatic build_table();
		// exact results, back to back
		add_vec("fmadd_exact",        fmadd,  rne, 16'h3e00, 16'h4000, 16'h3400, 16'h4280, 0, 0);
		add_vec("fmsub_exact",        fmsub,  rne, 16'h3e00, 16'h4000, 16'h3400, 16'h4180, 0, 0);
		add_vec("fnmadd_exact",       fnmadd, rne, 16'h3e00, 16'h4000, 16'h3400, 16'hc180, 0, 0);
		add_vec("fnmsub_exact",       fnmsub, rne, 16'h3e00, 16'h4000, 16'h3400, 16'hc280, 0, 0);
		add_vec("fmsub_z_wins",       fmsub,  rne, 16'h3c00, 16'h3e00, 16'h4000, 16'hb800, 0, 0);
		add_vec("zero_prod_plus_z",   fmadd,  rne, 16'h0000, 16'h3c00, 16'h4000, 16'h4000, 0, 0);
		// half ulp ties, below and above half
		add_vec("rne_tie_up",         fmadd,  rne, 16'h3c01, 16'h3c00, 16'h1000, 16'h3c02, 0, 0);
		add_vec("rne_tie_down",       fmadd,  rne, 16'h3c00, 16'h3c00, 16'h1000, 16'h3c00, 0, 0);
		add_vec("rdn_pos_tie",        fmadd,  rdn, 16'h3c01, 16'h3c00, 16'h1000, 16'h3c01, 0, 0);
		add_vec("rdn_neg_tie",        fnmsub, rdn, 16'h3c00, 16'h3c00, 16'h1000, 16'hbc01, 0, 0);
		add_vec("rne_neg_tie",        fnmsub, rne, 16'h3c00, 16'h3c00, 16'h1000, 16'hbc00, 0, 0);
		add_vec("rne_below_half",     fmadd,  rne, 16'h3c00, 16'h3c00, 16'h0c00, 16'h3c00, 0, 0);
		add_vec("rdn_neg_below_half", fnmsub, rdn, 16'h3c00, 16'h3c00, 16'h0c00, 16'hbc01, 0, 0);
		add_vec("rne_above_half",     fmadd,  rne, 16'h3c00, 16'h3c00, 16'h1200, 16'h3c01, 0, 0);
		add_vec("rdn_pos_above_half", fmadd,  rdn, 16'h3c00, 16'h3c00, 16'h1200, 16'h3c00, 0, 0);
		add_vec("rne_neg_above_half", fnmsub, rne, 16'h3c00, 16'h3c00, 16'h1200, 16'hbc01, 0, 0);
		add_vec("rne_sub_carry",      fmsub,  rne, 16'h3c00, 16'h3c00, 16'h0c00, 16'h3c00, 0, 0);
		add_vec("rdn_sub_trunc",      fmsub,  rdn, 16'h3c00, 16'h3c00, 16'h0c00, 16'h3bff, 0, 0);
		// signed zeros, with idle gaps
		add_vec("exact_zero_rne",     fmsub,  rne, 16'h3c00, 16'h3c00, 16'h3c00, 16'h0000, 0, 2);
		add_vec("exact_zero_rdn",     fmsub,  rdn, 16'h3c00, 16'h3c00, 16'h3c00, 16'h8000, 0, 2);
		add_vec("fnmadd_zero_rne",    fnmadd, rne, 16'h3c00, 16'h3c00, 16'h3c00, 16'h0000, 0, 2);
		add_vec("neg_zeros_keep",     fmadd,  rne, 16'h8000, 16'h3c00, 16'h8000, 16'h8000, 0, 2);
		add_vec("pos_zeros_rdn",      fmadd,  rdn, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 0, 2);
		add_vec("zero_sub_zero_rdn",  fmsub,  rdn, 16'h0000, 16'h3c00, 16'h0000, 16'h8000, 0, 2);
		// infinities and nans
		add_vec("inf_times_one",      fmadd,  rne, 16'h7c00, 16'h3c00, 16'h3c00, 16'h7c00, 0, 2);
		add_vec("neg_inf_prod",       fnmadd, rne, 16'h7c00, 16'h3c00, 16'h3c00, 16'hfc00, 0, 2);
		add_vec("z_inf_sub",          fmsub,  rne, 16'h3c00, 16'h3c00, 16'h7c00, 16'hfc00, 0, 2);
		add_vec("inf_plus_inf",       fmadd,  rne, 16'h7c00, 16'h3c00, 16'h7c00, 16'h7c00, 0, 2);
		add_vec("inf_times_zero",     fmadd,  rne, 16'h7c00, 16'h0000, 16'h3c00, 16'h7e00, 1, 2);
		add_vec("inf_minus_inf",      fmsub,  rne, 16'h7c00, 16'h3c00, 16'h7c00, 16'h7e00, 1, 2);
		add_vec("qnan_z",             fmadd,  rne, 16'h3c00, 16'h3c00, 16'h7e00, 16'h7e00, 1, 2);
		add_vec("snan_y",             fmadd,  rdn, 16'h3c00, 16'h7c01, 16'h3c00, 16'h7e00, 1, 2);
		// overflow, back to back again
		add_vec("ovf_rne",            fmadd,  rne, 16'h7bff, 16'h4000, 16'h0000, 16'h7c00, 0, 0);
		add_vec("ovf_rdn_pos",        fmadd,  rdn, 16'h7bff, 16'h4000, 16'h0000, 16'h7bff, 0, 0);
		add_vec("ovf_rdn_neg",        fnmadd, rdn, 16'h7bff, 16'h4000, 16'h0000, 16'hfc00, 0, 0);
		add_vec("ovf_rne_neg",        fnmadd, rne, 16'h7bff, 16'h4000, 16'h0000, 16'hfc00, 0, 0);
		add_vec("round_to_ovf_rne",   fmadd,  rne, 16'h7bff, 16'h3c00, 16'h4c00, 16'h7c00, 0, 0);
		add_vec("round_no_ovf_rdn",   fmadd,  rdn, 16'h7bff, 16'h3c00, 16'h4c00, 16'h7bff, 0, 0);
		// underflow flushes to a signed zero
		add_vec("unf_pos",            fmadd,  rne, 16'h0400, 16'h3800, 16'h0000, 16'h0000, 0, 1);
		add_vec("unf_neg",            fnmadd, rne, 16'h0400, 16'h3800, 16'h0000, 16'h8000, 0, 1);
		add_vec("unf_sub_neg",        fmsub,  rne, 16'h0400, 16'h3c00, 16'h0600, 16'h8000, 0, 1);
	endtask

	function automatic int error_total();
		return checker_inst.mismatches + checker_inst.protocol_errors
			+ fma_top_inst.fma_assertions_inst.fail_count;
	endfunction

	task automatic print_counts();
		$display("checked %0d of %0d, mismatches %0d, protocol errors %0d, assertion failures %0d",
			checker_inst.checked, vecs.size(), checker_inst.mismatches,
			checker_inst.protocol_errors, fma_top_inst.fma_assertions_inst.fail_count);
	endtask

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;   // 100 ns period
	end

	// stimulus
	initial begin
		int total;
		in_valid = 1'b0;
		op       = fmadd;
		rnd      = rne;
		x        = '0;
		y        = '0;
		z        = '0;
		rst_n    = 1'b0;
		build_table();
		total = 0;
		foreach (vecs[i])
			total += 1 + vecs[i].gap;
		limit = 4 + total + `FMA_LATENCY + 20;

		repeat (4) @(posedge clk);
		rst_n <= 1'b1;

		foreach (vecs[i]) begin
			@(posedge clk);
			in_valid <= 1'b1;
			op       <= vecs[i].op;
			rnd      <= vecs[i].rnd;
			x        <= vecs[i].x;
			y        <= vecs[i].y;
			z        <= vecs[i].z;
			checker_inst.expect_result(vecs[i].name, vecs[i].w, vecs[i].inv);
			repeat (vecs[i].gap) begin
				@(posedge clk);
				in_valid <= 1'b0;
			end
		end
		@(posedge clk);
		in_valid <= 1'b0;

		while (checker_inst.pending_count() > 0)
			@(posedge clk);
		repeat (`FMA_LATENCY + 2) @(posedge clk);   // room for a stray out_valid

		print_counts();
		if (error_total() == 0 && checker_inst.checked == vecs.size())
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	// watchdog
	initial begin
		wait (limit > 0);
		while (cycles <= limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles with %0d results outstanding",
			cycles, checker_inst.pending_count());
		print_counts();
		$display("TB FAILED");
		$finish;
	end

endmodule

// ==== tests/fma_assertions.sv ====
//////////////////////////////////////////////////
// bound assertions on fma_top
// reset, handshake latency, canonical nan
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "fma_defines.svh"

module fma_assertions (
	input logic                   clk,
	input logic                   rst_n,
	input logic                   in_valid,
	input logic                   out_valid,
	input logic [`FMA_WORD_W-1:0] w,
	input logic                   invalid
);
	int fail_count = 0;

	// strobe cleared by reset
	reset_quiet: assert property (@(posedge clk) !rst_n |=> !out_valid)
		else begin
			$error("out_valid high right after a reset cycle");
			fail_count++;
		end

	// fixed three stage latency, both directions
	latency_fwd: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid |-> ##`FMA_LATENCY out_valid)
		else begin
			$error("in_valid not followed by out_valid at the pipeline latency");
			fail_count++;
		end

	latency_back: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> $past(in_valid, `FMA_LATENCY))
		else begin
			$error("out_valid without an in_valid one pipeline latency earlier");
			fail_count++;
		end

	qnan_on_invalid: assert property (@(posedge clk) disable iff (!rst_n)
		invalid |-> w == 16'h7e00)
		else begin
			$error("invalid high but w is not the canonical quiet nan");
			fail_count++;
		end

endmodule

bind fma_top fma_assertions fma_assertions_inst (
	.clk       (clk),
	.rst_n     (rst_n),
	.in_valid  (in_valid),
	.out_valid (out_valid),
	.w         (w),
	.invalid   (invalid)
);

// ==== tests/fma_checker.sv ====
//////////////////////////////////////////////////
// result checker
// expected queue, latency tracking, compare
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "fma_defines.svh"

module fma_checker (
	input logic                   clk,
	input logic                   rst_n,
	input logic                   in_valid,
	input logic                   out_valid,
	input logic [`FMA_WORD_W-1:0] w,
	input logic                   invalid
);
	typedef struct {
		string                  name;
		logic [`FMA_WORD_W-1:0] w;
		logic                   inv;
		int                     due;   // cycle its out_valid is sampled
	} expect_t;

	expect_t queued_q[$];   // driven, not yet sampled by the dut
	expect_t flight_q[$];   // inside the pipeline
	int      cycle = 0;
	int      checked = 0;
	int      mismatches = 0;
	int      protocol_errors = 0;

	task automatic expect_result(input string name, input logic [`FMA_WORD_W-1:0] w_exp,
		input logic inv_exp);
		expect_t e;
		e.name = name;
		e.w    = w_exp;
		e.inv  = inv_exp;
		e.due  = 0;
		queued_q.push_back(e);
	endtask

	function automatic int pending_count();
		return queued_q.size() + flight_q.size();
	endfunction

	// all reads are pre-edge values
	always @(posedge clk) begin
		expect_t e;
		cycle = cycle + 1;
		if (rst_n) begin
			if (out_valid) begin
				if (flight_q.size() == 0) begin
					$display("out_valid at cycle %0d with no result pending", cycle);
					protocol_errors++;
				end else begin
					e = flight_q.pop_front();
					if (e.due != cycle) begin
						$display("%s arrived at cycle %0d, due at cycle %0d", e.name, cycle, e.due);
						protocol_errors++;
					end
					checked++;
					if (w !== e.w || invalid !== e.inv) begin
						$display("FAIL %s: expected w=%h invalid=%b, actual w=%h invalid=%b",
							e.name, e.w, e.inv, w, invalid);
						mismatches++;
					end
				end
			end else if (flight_q.size() > 0 && flight_q[0].due <= cycle) begin
				e = flight_q.pop_front();   // overdue, drop it
				$display("no out_valid for %s, it was due at cycle %0d", e.name, e.due);
				protocol_errors++;
			end

			// dut samples this operation now
			if (in_valid) begin
				if (queued_q.size() == 0) begin
					$display("in_valid at cycle %0d with no expected result queued", cycle);
					protocol_errors++;
				end else begin
					e = queued_q.pop_front();
					e.due = cycle + `FMA_LATENCY;
					flight_q.push_back(e);
				end
			end
		end
	end

endmodule

// ==== source/fma_top.sv ====
//////////////////////////////////////////////////
// fma top level, decode -> execute -> result
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "fma_defines.svh"

module fma_top (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   in_valid,
	input  fma_pkg::fma_op_e       op,
	input  fma_pkg::fma_rnd_e      rnd,
	input  logic [`FMA_WORD_W-1:0] x,
	input  logic [`FMA_WORD_W-1:0] y,
	input  logic [`FMA_WORD_W-1:0] z,
	output logic                   out_valid,
	output logic [`FMA_WORD_W-1:0] w,
	output logic                   invalid
);
	import fma_pkg::*;

	// decode to execute
	logic                   d_valid;
	fma_rnd_e               d_rnd;
	logic                   xsign;
	logic                   ysign;
	logic                   zsign;
	logic [`FMA_EXP_W-1:0]  xexp;
	logic [`FMA_EXP_W-1:0]  yexp;
	logic [`FMA_EXP_W-1:0]  zexp;
	logic [`FMA_SIG_W-1:0]  xman;
	logic [`FMA_SIG_W-1:0]  yman;
	logic [`FMA_SIG_W-1:0]  zman;
	logic                   killprod;
	logic                   inf;
	logic                   zinf;
	logic                   nan;
	logic                   d_invalid;

	// execute to result
	logic                          e_valid;
	fma_rnd_e                      e_rnd;
	logic                          wsign;
	logic [`FMA_SUM_W-1:0]         sum;
	logic                          sumzero;
	logic signed [`FMA_REXP_W-1:0] rexp;
	logic                          sticky;
	logic                          e_inf;
	logic                          e_nan;
	logic                          e_invalid;

	// one register per stage
	if (`FMA_LATENCY != 3) begin : g_latency_check
		$error("FMA_LATENCY does not match the three stage pipeline");
	end

	fma_decode fma_decode_inst (
		.invalid (d_invalid),
		.*
	);

	fma_execute fma_execute_inst (
		.invalid (d_invalid),
		.*
	);

	fma_result fma_result_inst (.*);

endmodule

// ==== source/fma_result.sv ====
//////////////////////////////////////////////////
// result stage
// normalize, round, overflow and special value packing
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "fma_defines.svh"

module fma_result (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          e_valid,
	input  fma_pkg::fma_rnd_e             e_rnd,
	input  logic                          wsign,
	input  logic [`FMA_SUM_W-1:0]         sum,
	input  logic                          sumzero,
	input  logic signed [`FMA_REXP_W-1:0] rexp,
	input  logic                          sticky,
	input  logic                          e_inf,
	input  logic                          e_nan,
	input  logic                          e_invalid,
	output logic                          out_valid,
	output logic [`FMA_WORD_W-1:0]        w,
	output logic                          invalid
);
	import fma_pkg::*;

	localparam logic [`FMA_WORD_W-1:0] qnan    = 16'h7e00;
	localparam logic [`FMA_WORD_W-1:0] max_pos = 16'h7bff;   // largest finite
	localparam int                     exp_max = (1 << `FMA_EXP_W) - 1;

	logic [5:0]                    lz;       // leading zeros of sum
	logic [`FMA_SUM_W-1:0]         norm;
	logic signed [`FMA_REXP_W-1:0] exp_n;
	logic signed [`FMA_REXP_W-1:0] exp_r;
	logic                          lsb;
	logic                          guard;
	logic                          rest;
	logic                          inc;
	logic [`FMA_SIG_W:0]           mant_r;   // carry out on top
	logic [`FMA_WORD_W-1:0]        w_c;

	// highest set bit wins
	always_comb begin
		lz = '0;
		for (int i = 0; i < `FMA_SUM_W; i++)
			if (sum[i])
				lz = 6'(`FMA_SUM_W - 1 - i);
	end

	assign norm  = sum << lz;   // leading one at the msb
	assign exp_n = rexp + `FMA_REXP_W'(2) - `FMA_REXP_W'(lz);   // frame ref sits 2 below msb

	//////////////////////////////////////////////////
	// rounding
	//////////////////////////////////////////////////
	assign lsb   = norm[`FMA_SUM_W-`FMA_SIG_W];
	assign guard = norm[`FMA_SUM_W-`FMA_SIG_W-1];
	assign rest  = (|norm[`FMA_SUM_W-`FMA_SIG_W-2:0]) | sticky;

	// rdn bumps the magnitude only for negative inexact values
	assign inc = (e_rnd == rne) ? guard & (rest | lsb) : wsign & (guard | rest);

	assign mant_r = {1'b0, norm[`FMA_SUM_W-1 -: `FMA_SIG_W]} + (`FMA_SIG_W+1)'(inc);
	assign exp_r  = exp_n + `FMA_REXP_W'(mant_r[`FMA_SIG_W]);   // 1.11..1 rounds to 10.0

	always_comb begin
		if (e_nan || e_invalid)
			w_c = qnan;
		else if (e_inf)
			w_c = {wsign, {`FMA_EXP_W{1'b1}}, {`FMA_MAN_W{1'b0}}};
		else if (sumzero || exp_r <= 0)
			w_c = {wsign, {(`FMA_WORD_W-1){1'b0}}};   // exact zero or flushed underflow
		else if (exp_r >= exp_max) begin
			if (e_rnd == rdn && !wsign)
				w_c = max_pos;
			else
				w_c = {wsign, {`FMA_EXP_W{1'b1}}, {`FMA_MAN_W{1'b0}}};
		end else
			w_c = {wsign, exp_r[`FMA_EXP_W-1:0], mant_r[`FMA_MAN_W-1:0]};
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			invalid   <= 1'b0;
		end else begin
			out_valid <= e_valid;
			invalid   <= e_valid & e_invalid;   // pulses with its result only
		end
	end

	always_ff @(posedge clk) begin
		w <= w_c;
	end

endmodule

// ==== source/fma_execute.sv ====
//////////////////////////////////////////////////
// execute stage
// significand multiply, addend align, compound adder, sign unit
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "fma_defines.svh"

module fma_execute (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          d_valid,
	input  fma_pkg::fma_rnd_e             d_rnd,
	input  logic                          xsign,
	input  logic                          ysign,
	input  logic                          zsign,
	input  logic [`FMA_EXP_W-1:0]         xexp,
	input  logic [`FMA_EXP_W-1:0]         yexp,
	input  logic [`FMA_EXP_W-1:0]         zexp,
	input  logic [`FMA_SIG_W-1:0]         xman,
	input  logic [`FMA_SIG_W-1:0]         yman,
	input  logic [`FMA_SIG_W-1:0]         zman,
	input  logic                          killprod,
	input  logic                          inf,
	input  logic                          zinf,
	input  logic                          nan,
	input  logic                          invalid,
	output logic                          e_valid,
	output fma_pkg::fma_rnd_e             e_rnd,
	output logic                          wsign,
	output logic [`FMA_SUM_W-1:0]         sum,       // magnitude
	output logic                          sumzero,
	output logic signed [`FMA_REXP_W-1:0] rexp,      // biased exp of frame bit z_top
	output logic                          sticky,
	output logic                          e_inf,
	output logic                          e_nan,
	output logic                          e_invalid
);
	localparam int z_top     = `FMA_SUM_W - 3;    // z hidden bit, two bits of headroom
	localparam int p_point   = `FMA_PROD_W - 1;   // product binary point in the frame
	localparam int align_off = z_top - p_point;

	logic [`FMA_PROD_W-1:0]        prod;
	logic signed [`FMA_REXP_W-1:0] pexp;
	logic signed [`FMA_REXP_W-1:0] amt_raw;
	logic signed [`FMA_REXP_W-1:0] rexp_c;
	logic                          zdom;      // z alone sets the frame
	logic [6:0]                    shamt;
	logic [`FMA_SUM_W-1:0]         zfield;
	logic [`FMA_SUM_W-1:0]         zal;
	logic [`FMA_SUM_W-1:0]         zlost;
	logic [`FMA_SUM_W-1:0]         zadd;
	logic [`FMA_SUM_W-1:0]         zop;
	logic [`FMA_SUM_W-1:0]         pfield;
	logic [`FMA_SUM_W-1:0]         sum0;
	logic [`FMA_SUM_W-1:0]         sum1;
	logic [`FMA_SUM_W-1:0]         sel;
	logic [`FMA_SUM_W-1:0]         mag;
	logic                          zsticky;
	logic                          psticky;
	logic                          invz;
	logic                          negsum;
	logic                          selsum1;
	logic                          sumzero_c;
	logic                          wsign_c;

	//////////////////////////////////////////////////
	// product and alignment
	//////////////////////////////////////////////////
	assign prod    = xman * yman;
	assign pexp    = `FMA_REXP_W'(xexp) + `FMA_REXP_W'(yexp) - `FMA_REXP_W'(`FMA_BIAS);
	assign amt_raw = pexp + `FMA_REXP_W'(align_off) - `FMA_REXP_W'(zexp);
	assign zdom    = killprod || (amt_raw < 0);   // product far below z
	assign rexp_c  = zdom ? `FMA_REXP_W'(zexp) : pexp + `FMA_REXP_W'(align_off);

	always_comb begin
		if (zdom)
			shamt = '0;
		else if (amt_raw > `FMA_SUM_W)
			shamt = 7'(`FMA_SUM_W);   // everything lands in sticky
		else
			shamt = amt_raw[6:0];
	end

	assign zfield = {2'b00, zman, {(`FMA_SUM_W-`FMA_SIG_W-2){1'b0}}};
	assign {zal, zlost} = {zfield, {`FMA_SUM_W{1'b0}}} >> shamt;
	assign zsticky = |zlost;
	assign zadd    = {zal[`FMA_SUM_W-1:1], zal[0] | zsticky};   // jam lost bits into lsb

	// a product below z only counts as a jammed lsb
	assign psticky = ~killprod & (amt_raw < 0);
	assign pfield  = killprod ? '0
		: psticky ? `FMA_SUM_W'(1)
		: {{(`FMA_SUM_W-`FMA_PROD_W-1){1'b0}}, prod, 1'b0};

	//////////////////////////////////////////////////
	// compound adder
	//////////////////////////////////////////////////
	assign zop  = invz ? ~zadd : zadd;
	assign sum0 = pfield + zop;
	assign sum1 = sum0 + 1'b1;   // two's complement finish for p-z

	assign sumzero_c = invz ? (sum1 == '0) : (sum0 == '0);
	assign sel       = selsum1 ? sum1 : sum0;
	assign mag       = negsum ? ~sel : sel;

	fma_sign sign_inst (
		.xsign    (xsign),
		.ysign    (ysign),
		.zsign    (zsign),
		.negsum0  (sum0[`FMA_SUM_W-1]),
		.negsum1  (sum1[`FMA_SUM_W-1]),
		.killprod (killprod),
		.rm       (d_rnd),
		.sumzero  (sumzero_c),
		.invalid  (invalid),
		.zinf     (zinf),
		.inf      (inf),
		.psign    (),
		.invz     (invz),
		.negsum   (negsum),
		.selsum1  (selsum1),
		.wsign    (wsign_c)
	);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			e_valid   <= 1'b0;
			e_inf     <= 1'b0;
			e_nan     <= 1'b0;
			e_invalid <= 1'b0;
		end else begin
			e_valid   <= d_valid;
			e_inf     <= inf;
			e_nan     <= nan;
			e_invalid <= invalid;
		end
	end

	always_ff @(posedge clk) begin
		e_rnd   <= d_rnd;
		wsign   <= wsign_c;
		sum     <= mag;
		sumzero <= sumzero_c;
		rexp    <= rexp_c;
		sticky  <= zsticky | psticky;
	end

endmodule

// ==== source/fma_sign.sv ====
//////////////////////////////////////////////////
// sign unit
// addend inversion, adder output select and negate, result sign
//////////////////////////////////////////////////
`timescale 1ns/10ps

module fma_sign (
	input  logic              xsign,     // effective x sign
	input  logic              ysign,
	input  logic              zsign,     // effective z sign
	input  logic              negsum0,   // sum is negative
	input  logic              negsum1,   // sum+1 is negative
	input  logic              killprod,  // product is zero
	input  fma_pkg::fma_rnd_e rm,
	input  logic              sumzero,   // exact zero sum
	input  logic              invalid,
	input  logic              zinf,
	input  logic              inf,       // some operand infinite
	output logic              psign,
	output logic              invz,      // invert z into the adder
	output logic              negsum,    // negate the selected sum
	output logic              selsum1,   // take sum+1 from the compound adder
	output logic              wsign
);
	import fma_pkg::*;

	logic zerosign;   // sign of an exact zero
	logic infsign;    // sign of an infinite result

	assign psign = xsign ^ ysign;
	assign invz  = zsign ^ psign;   // effective subtraction

	// subtraction: p-z is sum+1 when positive, ~sum when negative
	assign selsum1 = invz & ~negsum1;
	assign negsum  = selsum1 ? negsum1 : negsum0;

	// x+x keeps its sign at zero, x-x gives +0 except in rdn
	assign zerosign = (~invz & killprod) ? zsign : (rm == rdn);
	assign infsign  = zinf ? zsign : psign;

	always_comb begin
		if (invalid)
			wsign = 1'b0;             // canonical nan
		else if (inf)
			wsign = infsign;
		else if (sumzero)
			wsign = zerosign;
		else
			wsign = psign ^ negsum;   // flips when |z| wins the subtraction
	end

endmodule

// ==== source/fma_decode.sv ====
//////////////////////////////////////////////////
// decode stage
// operand unpack, special value classes, opcode sign flips
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "fma_defines.svh"

module fma_decode (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    in_valid,
	input  fma_pkg::fma_op_e        op,
	input  fma_pkg::fma_rnd_e       rnd,
	input  logic [`FMA_WORD_W-1:0]  x,
	input  logic [`FMA_WORD_W-1:0]  y,
	input  logic [`FMA_WORD_W-1:0]  z,
	output logic                    d_valid,
	output fma_pkg::fma_rnd_e       d_rnd,
	output logic                    xsign,
	output logic                    ysign,
	output logic                    zsign,
	output logic [`FMA_EXP_W-1:0]   xexp,
	output logic [`FMA_EXP_W-1:0]   yexp,
	output logic [`FMA_EXP_W-1:0]   zexp,
	output logic [`FMA_SIG_W-1:0]   xman,
	output logic [`FMA_SIG_W-1:0]   yman,
	output logic [`FMA_SIG_W-1:0]   zman,
	output logic                    killprod,
	output logic                    inf,
	output logic                    zinf,
	output logic                    nan,
	output logic                    invalid
);
	import fma_pkg::*;

	logic xs_eff;      // x sign after fnm flip
	logic zs_eff;      // z sign after sub flip
	logic pzero;
	logic pinf;
	logic any_nan;
	logic inv_c;

	function automatic logic [`FMA_EXP_W-1:0] exp_of(input logic [`FMA_WORD_W-1:0] v);
		return v[`FMA_WORD_W-2 -: `FMA_EXP_W];
	endfunction

	// hidden bit restored for normals, subnormals flush to zero
	function automatic logic [`FMA_SIG_W-1:0] sig_of(input logic [`FMA_WORD_W-1:0] v);
		return (exp_of(v) == '0) ? '0 : {1'b1, v[`FMA_MAN_W-1:0]};
	endfunction

	function automatic logic is_nan(input logic [`FMA_WORD_W-1:0] v);
		return (&exp_of(v)) && (|v[`FMA_MAN_W-1:0]);
	endfunction

	function automatic logic is_inf(input logic [`FMA_WORD_W-1:0] v);
		return (&exp_of(v)) && (v[`FMA_MAN_W-1:0] == '0);
	endfunction

	assign xs_eff  = x[`FMA_WORD_W-1] ^ (op == fnmadd || op == fnmsub);
	assign zs_eff  = z[`FMA_WORD_W-1] ^ (op == fmsub || op == fnmsub);
	assign pzero   = (exp_of(x) == '0) || (exp_of(y) == '0);   // zero or flushed subnormal
	assign pinf    = is_inf(x) | is_inf(y);
	assign any_nan = is_nan(x) | is_nan(y) | is_nan(z);

	// any nan, inf*0, or inf-inf once the effective signs are known
	assign inv_c = any_nan | (pinf & pzero)
		| (pinf & ~pzero & is_inf(z) & (xs_eff ^ y[`FMA_WORD_W-1] ^ zs_eff));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			d_valid  <= 1'b0;
			killprod <= 1'b0;
			inf      <= 1'b0;
			zinf     <= 1'b0;
			nan      <= 1'b0;
			invalid  <= 1'b0;
		end else begin
			d_valid  <= in_valid;
			killprod <= pzero;
			inf      <= pinf | is_inf(z);
			zinf     <= is_inf(z);
			nan      <= any_nan;
			invalid  <= inv_c;
		end
	end

	// operand payload
	always_ff @(posedge clk) begin
		d_rnd <= rnd;
		xsign <= xs_eff;
		ysign <= y[`FMA_WORD_W-1];
		zsign <= zs_eff;
		xexp  <= exp_of(x);
		yexp  <= exp_of(y);
		zexp  <= exp_of(z);
		xman  <= sig_of(x);
		yman  <= sig_of(y);
		zman  <= sig_of(z);
	end

endmodule

// ==== source/fma_pkg.sv ====
//////////////////////////////////////////////////
// opcode and rounding mode types
//////////////////////////////////////////////////
package fma_pkg;

	// fnm forms negate the product
	// the sub forms negate z
	typedef enum logic [1:0] {
		fmadd  = 2'b00,
		fmsub  = 2'b01,
		fnmadd = 2'b10,
		fnmsub = 2'b11
	} fma_op_e;

	typedef enum logic {
		rne = 1'b0,    // nearest, ties to even
		rdn = 1'b1     // toward minus infinity
	} fma_rnd_e;

endpackage

// ==== source/fma_defines.svh ====
//////////////////////////////////////////////////
// binary16 field widths and fma datapath sizes
//////////////////////////////////////////////////
`ifndef FMA_DEFINES_SVH
`define FMA_DEFINES_SVH

// binary16 format
`define FMA_EXP_W   5
`define FMA_MAN_W   10
`define FMA_SIG_W   11   // mantissa plus hidden bit
`define FMA_WORD_W  16
`define FMA_BIAS    15

// internal datapath
`define FMA_PROD_W  22   // 11x11 significand product
`define FMA_SUM_W   36   // aligned addend, adder, guard and sticky room
`define FMA_REXP_W  8    // signed exponent before normalization

// decode, execute, result
`define FMA_LATENCY 3

`endif
